/* rv_pkg.sv */
package rv_pkg;

    // datapath and field widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic        a_src_t;
    typedef logic [1:0]  b_src_t;
    typedef logic [2:0]  branch_t;
    typedef logic [2:0]  mem_op_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu operations
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    localparam alu_op_t ALU_COPYB = 4'd10;

    // branch compares, result lands in bit 0
    localparam alu_op_t ALU_EQ    = 4'd11;
    localparam alu_op_t ALU_NE    = 4'd12;
    localparam alu_op_t ALU_GE    = 4'd13;
    localparam alu_op_t ALU_GEU   = 4'd14;
    // less-than compares share the slt/sltu encodings
    localparam alu_op_t ALU_LT    = ALU_SLT;
    localparam alu_op_t ALU_LTU   = ALU_SLTU;

    // operand a source
    localparam a_src_t A_RS1 = 1'b0;
    localparam a_src_t A_PC  = 1'b1;

    // operand b source
    localparam b_src_t B_RS2  = 2'd0;
    localparam b_src_t B_IMM  = 2'd1;
    localparam b_src_t B_FOUR = 2'd2;

    // control transfer kind
    localparam branch_t BR_NONE = 3'd0;
    localparam branch_t BR_COND = 3'd1;
    localparam branch_t BR_JAL  = 3'd2;
    localparam branch_t BR_JALR = 3'd3;

endpackage

/* rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic              clk,
    input  logic              i_arst_n,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    input  logic              i_wr_en,
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::word_t     i_wr_data,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);
    import rv_pkg::*;

    // x1..x31 only, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // old value is returned when the same register is written this cycle
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* rv_idu.sv */
`timescale 1ns/100ps

module rv_idu (
    input  rv_pkg::inst_t     i_inst,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    output rv_pkg::reg_addr_t o_rd,
    output rv_pkg::a_src_t    o_alu_a_src,
    output rv_pkg::b_src_t    o_alu_b_src,
    output rv_pkg::alu_op_t   o_alu_op,
    output rv_pkg::branch_t   o_branch,
    output rv_pkg::mem_op_t   o_mem_op,
    output logic              o_mem_wr,
    output logic              o_reg_wr,
    output rv_pkg::word_t     o_rs1_val,
    output rv_pkg::word_t     o_rs2_val,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::word_t     o_pc
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // register-register and register-immediate arithmetic
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];

    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];
    assign o_rd       = i_inst[11:7];

    // immediate formats
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    always_comb begin
        o_alu_a_src = A_RS1;
        o_alu_b_src = B_IMM;
        o_alu_op    = ALU_ADD;
        o_branch    = BR_NONE;
        o_mem_op    = '0;
        o_mem_wr    = 1'b0;
        o_reg_wr    = 1'b0;
        o_imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                o_alu_b_src = B_RS2;
                o_alu_op    = arith_op(funct3, i_inst[30]);
                o_reg_wr    = 1'b1;
            end
            OPC_OP_IMM: begin
                // inst[30] is an immediate bit except for srai
                o_alu_op = arith_op(funct3, (funct3 == 3'b101) && i_inst[30]);
                o_reg_wr = 1'b1;
            end
            OPC_LUI: begin
                o_alu_op = ALU_COPYB;
                o_imm    = imm_u;
                o_reg_wr = 1'b1;
            end
            OPC_AUIPC: begin
                o_alu_a_src = A_PC;
                o_imm       = imm_u;
                o_reg_wr    = 1'b1;
            end
            OPC_JAL: begin
                // link value pc+4 comes from the alu
                o_alu_a_src = A_PC;
                o_alu_b_src = B_FOUR;
                o_branch    = BR_JAL;
                o_imm       = imm_j;
                o_reg_wr    = 1'b1;
            end
            OPC_JALR: begin
                o_alu_a_src = A_PC;
                o_alu_b_src = B_FOUR;
                o_branch    = BR_JALR;
                o_reg_wr    = 1'b1;
            end
            OPC_BRANCH: begin
                o_alu_b_src = B_RS2;
                o_branch    = BR_COND;
                o_imm       = imm_b;
                case (funct3)
                    3'b000:  o_alu_op = ALU_EQ;
                    3'b001:  o_alu_op = ALU_NE;
                    3'b100:  o_alu_op = ALU_LT;
                    3'b101:  o_alu_op = ALU_GE;
                    3'b110:  o_alu_op = ALU_LTU;
                    3'b111:  o_alu_op = ALU_GEU;
                    // reserved conditions never redirect
                    default: o_branch = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                o_mem_op = funct3;
                o_reg_wr = 1'b1;
            end
            OPC_STORE: begin
                o_mem_op = funct3;
                o_mem_wr = 1'b1;
                o_imm    = imm_s;
            end
            default: begin
            end
        endcase
    end

    assign o_rs1_val = i_rs1_data;
    assign o_rs2_val = i_rs2_data;
    assign o_pc      = i_pc;

endmodule

/* rv_id_exu_regs.sv */
`timescale 1ns/100ps

module rv_id_exu_regs (
    input  logic              clk,
    input  logic              i_arst_n,
    // decoded fields from the decoder
    input  rv_pkg::a_src_t    i_alu_a_src,
    input  rv_pkg::b_src_t    i_alu_b_src,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  rv_pkg::branch_t   i_branch,
    input  rv_pkg::mem_op_t   i_mem_op,
    input  logic              i_mem_wr,
    input  logic              i_reg_wr,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_rs1_val,
    input  rv_pkg::word_t     i_rs2_val,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::word_t     i_pc,
    // held fields for the execute unit
    output rv_pkg::a_src_t    o_alu_a_src,
    output rv_pkg::b_src_t    o_alu_b_src,
    output rv_pkg::alu_op_t   o_alu_op,
    output rv_pkg::branch_t   o_branch,
    output rv_pkg::mem_op_t   o_mem_op,
    output logic              o_mem_wr,
    output logic              o_reg_wr,
    output rv_pkg::reg_addr_t o_rd,
    output rv_pkg::word_t     o_rs1_val,
    output rv_pkg::word_t     o_rs2_val,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::word_t     o_pc,
    // handshake
    input  logic              i_id_valid,
    output logic              o_allow_in,
    input  logic              i_exu_ready,
    output logic              o_exu_valid
);
    logic load;

    // accept when empty or when the held item leaves this cycle
    assign o_allow_in = !o_exu_valid || i_exu_ready;
    assign load       = i_id_valid && o_allow_in;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exu_valid <= 1'b0;
        end else if (o_allow_in) begin
            o_exu_valid <= i_id_valid;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_alu_a_src <= '0;
            o_alu_b_src <= '0;
            o_alu_op    <= '0;
            o_branch    <= '0;
            o_mem_op    <= '0;
            o_mem_wr    <= 1'b0;
            o_reg_wr    <= 1'b0;
            o_rd        <= '0;
            o_rs1_val   <= '0;
            o_rs2_val   <= '0;
            o_imm       <= '0;
            o_pc        <= '0;
        end else if (load) begin
            o_alu_a_src <= i_alu_a_src;
            o_alu_b_src <= i_alu_b_src;
            o_alu_op    <= i_alu_op;
            o_branch    <= i_branch;
            o_mem_op    <= i_mem_op;
            o_mem_wr    <= i_mem_wr;
            o_reg_wr    <= i_reg_wr;
            o_rd        <= i_rd;
            o_rs1_val   <= i_rs1_val;
            o_rs2_val   <= i_rs2_val;
            o_imm       <= i_imm;
            o_pc        <= i_pc;
        end
    end

endmodule

/* rv_exu.sv */
`timescale 1ns/100ps

module rv_exu (
    input  rv_pkg::a_src_t    i_alu_a_src,
    input  rv_pkg::b_src_t    i_alu_b_src,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  rv_pkg::branch_t   i_branch,
    input  rv_pkg::mem_op_t   i_mem_op,
    input  logic              i_mem_wr,
    input  logic              i_reg_wr,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_rs1_val,
    input  rv_pkg::word_t     i_rs2_val,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::word_t     i_pc,
    output rv_pkg::word_t     o_result,
    output rv_pkg::reg_addr_t o_rd,
    output logic              o_reg_wr,
    output logic              o_redirect,
    output rv_pkg::word_t     o_redirect_pc,
    output rv_pkg::word_t     o_mem_addr,
    output rv_pkg::mem_op_t   o_mem_op,
    output logic              o_mem_wr,
    output rv_pkg::word_t     o_mem_wdata
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    word_t      rs1_plus_imm;
    word_t      pc_plus_imm;
    logic [4:0] shamt;

    // operand selection
    assign op_a = (i_alu_a_src == A_PC) ? i_pc : i_rs1_val;

    always_comb begin
        case (i_alu_b_src)
            B_RS2:   op_b = i_rs2_val;
            B_IMM:   op_b = i_imm;
            B_FOUR:  op_b = 32'd4;
            default: op_b = '0;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:   alu_out = op_a + op_b;
            ALU_SUB:   alu_out = op_a - op_b;
            ALU_SLL:   alu_out = op_a << shamt;
            ALU_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_out = {31'b0, op_a < op_b};
            ALU_XOR:   alu_out = op_a ^ op_b;
            ALU_SRL:   alu_out = op_a >> shamt;
            ALU_SRA:   alu_out = word_t'($signed(op_a) >>> shamt);
            ALU_OR:    alu_out = op_a | op_b;
            ALU_AND:   alu_out = op_a & op_b;
            ALU_COPYB: alu_out = op_b;
            ALU_EQ:    alu_out = {31'b0, op_a == op_b};
            ALU_NE:    alu_out = {31'b0, op_a != op_b};
            ALU_GE:    alu_out = {31'b0, $signed(op_a) >= $signed(op_b)};
            ALU_GEU:   alu_out = {31'b0, op_a >= op_b};
            default:   alu_out = '0;
        endcase
    end

    assign rs1_plus_imm = i_rs1_val + i_imm;
    assign pc_plus_imm  = i_pc + i_imm;

    // redirect, taken flag comes from the compare in bit 0
    always_comb begin
        o_redirect    = 1'b0;
        o_redirect_pc = pc_plus_imm;
        case (i_branch)
            BR_COND: o_redirect = alu_out[0];
            BR_JAL:  o_redirect = 1'b1;
            BR_JALR: begin
                o_redirect    = 1'b1;
                o_redirect_pc = {rs1_plus_imm[31:1], 1'b0};
            end
            default: begin
            end
        endcase
    end

    assign o_result = alu_out;
    assign o_rd     = i_rd;
    assign o_reg_wr = i_reg_wr;

    // request fields for the load/store unit
    assign o_mem_addr  = rs1_plus_imm;
    assign o_mem_op    = i_mem_op;
    assign o_mem_wr    = i_mem_wr;
    assign o_mem_wdata = i_rs2_val;

endmodule

/* rv_core_ex.sv */
`timescale 1ns/100ps

module rv_core_ex (
    input  logic              clk,
    input  logic              i_arst_n,
    // fetch side
    input  logic              i_inst_valid,
    input  rv_pkg::inst_t     i_inst,
    input  rv_pkg::word_t     i_pc,
    output logic              o_inst_allow_in,
    // execute side
    input  logic              i_exu_ready,
    output logic              o_exu_valid,
    output rv_pkg::word_t     o_result,
    output rv_pkg::reg_addr_t o_rd,
    output logic              o_reg_wr,
    output logic              o_redirect,
    output rv_pkg::word_t     o_redirect_pc,
    output rv_pkg::word_t     o_mem_addr,
    output rv_pkg::mem_op_t   o_mem_op,
    output logic              o_mem_wr,
    output rv_pkg::word_t     o_mem_wdata,
    // write-back port
    input  logic              i_wb_en,
    input  rv_pkg::reg_addr_t i_wb_rd,
    input  rv_pkg::word_t     i_wb_data
);
    import rv_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // decoder outputs
    a_src_t    id_alu_a_src;
    b_src_t    id_alu_b_src;
    alu_op_t   id_alu_op;
    branch_t   id_branch;
    mem_op_t   id_mem_op;
    logic      id_mem_wr;
    logic      id_reg_wr;
    reg_addr_t id_rd;
    word_t     id_rs1_val;
    word_t     id_rs2_val;
    word_t     id_imm;
    word_t     id_pc;

    // held fields
    a_src_t    ex_alu_a_src;
    b_src_t    ex_alu_b_src;
    alu_op_t   ex_alu_op;
    branch_t   ex_branch;
    mem_op_t   ex_mem_op;
    logic      ex_mem_wr;
    logic      ex_reg_wr;
    reg_addr_t ex_rd;
    word_t     ex_rs1_val;
    word_t     ex_rs2_val;
    word_t     ex_imm;
    word_t     ex_pc;

    rv_regfile u_regfile (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wr_en    (i_wb_en),
        .i_wr_addr  (i_wb_rd),
        .i_wr_data  (i_wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_idu u_idu (
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .o_rd        (id_rd),
        .o_alu_a_src (id_alu_a_src),
        .o_alu_b_src (id_alu_b_src),
        .o_alu_op    (id_alu_op),
        .o_branch    (id_branch),
        .o_mem_op    (id_mem_op),
        .o_mem_wr    (id_mem_wr),
        .o_reg_wr    (id_reg_wr),
        .o_rs1_val   (id_rs1_val),
        .o_rs2_val   (id_rs2_val),
        .o_imm       (id_imm),
        .o_pc        (id_pc)
    );

    rv_id_exu_regs u_id_exu_regs (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_alu_a_src (id_alu_a_src),
        .i_alu_b_src (id_alu_b_src),
        .i_alu_op    (id_alu_op),
        .i_branch    (id_branch),
        .i_mem_op    (id_mem_op),
        .i_mem_wr    (id_mem_wr),
        .i_reg_wr    (id_reg_wr),
        .i_rd        (id_rd),
        .i_rs1_val   (id_rs1_val),
        .i_rs2_val   (id_rs2_val),
        .i_imm       (id_imm),
        .i_pc        (id_pc),
        .o_alu_a_src (ex_alu_a_src),
        .o_alu_b_src (ex_alu_b_src),
        .o_alu_op    (ex_alu_op),
        .o_branch    (ex_branch),
        .o_mem_op    (ex_mem_op),
        .o_mem_wr    (ex_mem_wr),
        .o_reg_wr    (ex_reg_wr),
        .o_rd        (ex_rd),
        .o_rs1_val   (ex_rs1_val),
        .o_rs2_val   (ex_rs2_val),
        .o_imm       (ex_imm),
        .o_pc        (ex_pc),
        .i_id_valid  (i_inst_valid),
        .o_allow_in  (o_inst_allow_in),
        .i_exu_ready (i_exu_ready),
        .o_exu_valid (o_exu_valid)
    );

    rv_exu u_exu (
        .i_alu_a_src   (ex_alu_a_src),
        .i_alu_b_src   (ex_alu_b_src),
        .i_alu_op      (ex_alu_op),
        .i_branch      (ex_branch),
        .i_mem_op      (ex_mem_op),
        .i_mem_wr      (ex_mem_wr),
        .i_reg_wr      (ex_reg_wr),
        .i_rd          (ex_rd),
        .i_rs1_val     (ex_rs1_val),
        .i_rs2_val     (ex_rs2_val),
        .i_imm         (ex_imm),
        .i_pc          (ex_pc),
        .o_result      (o_result),
        .o_rd          (o_rd),
        .o_reg_wr      (o_reg_wr),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mem_addr    (o_mem_addr),
        .o_mem_op      (o_mem_op),
        .o_mem_wr      (o_mem_wr),
        .o_mem_wdata   (o_mem_wdata)
    );

endmodule

/* rv_core_ex_tb.sv */
`timescale 1ns/100ps

module rv_core_ex_tb;
    import rv_pkg::*;

    localparam int MAX_ENTRIES = 64;

    logic      clk;
    logic      i_arst_n;
    logic      i_inst_valid;
    inst_t     i_inst;
    word_t     i_pc;
    logic      o_inst_allow_in;
    logic      i_exu_ready;
    logic      o_exu_valid;
    word_t     o_result;
    reg_addr_t o_rd;
    logic      o_reg_wr;
    logic      o_redirect;
    word_t     o_redirect_pc;
    word_t     o_mem_addr;
    mem_op_t   o_mem_op;
    logic      o_mem_wr;
    word_t     o_mem_wdata;
    logic      i_wb_en;
    reg_addr_t i_wb_rd;
    word_t     i_wb_data;

    // stimulus and expectation table
    inst_t     t_inst  [MAX_ENTRIES];
    word_t     t_pc    [MAX_ENTRIES];
    word_t     t_res   [MAX_ENTRIES];
    word_t     t_tgt   [MAX_ENTRIES];
    word_t     t_addr  [MAX_ENTRIES];
    word_t     t_wdata [MAX_ENTRIES];
    reg_addr_t t_rd    [MAX_ENTRIES];
    mem_op_t   t_op    [MAX_ENTRIES];
    logic      t_regwr [MAX_ENTRIES];
    logic      t_redir [MAX_ENTRIES];
    logic      t_memwr [MAX_ENTRIES];
    logic      t_chkres[MAX_ENTRIES];
    logic      t_chktgt[MAX_ENTRIES];
    logic      t_chkmem[MAX_ENTRIES];
    int        n_entries;
    word_t     cur_pc;
    word_t     preload [1:15];

    int        issued_q[$];
    int        pops;
    logic      was_stalled;
    word_t     snap_result;
    word_t     snap_tgt;
    word_t     snap_addr;

    rv_core_ex uut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_inst_valid    (i_inst_valid),
        .i_inst          (i_inst),
        .i_pc            (i_pc),
        .o_inst_allow_in (o_inst_allow_in),
        .i_exu_ready     (i_exu_ready),
        .o_exu_valid     (o_exu_valid),
        .o_result        (o_result),
        .o_rd            (o_rd),
        .o_reg_wr        (o_reg_wr),
        .o_redirect      (o_redirect),
        .o_redirect_pc   (o_redirect_pc),
        .o_mem_addr      (o_mem_addr),
        .o_mem_op        (o_mem_op),
        .o_mem_wr        (o_mem_wr),
        .o_mem_wdata     (o_mem_wdata),
        .i_wb_en         (i_wb_en),
        .i_wb_rd         (i_wb_rd),
        .i_wb_data       (i_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // instruction encoders
    function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        r_type = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        i_type = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_entry(input inst_t inst, input logic regwr, input reg_addr_t rd,
                             input logic chkres, input word_t res, input logic redir,
                             input logic chktgt, input word_t tgt, input logic memwr,
                             input logic chkmem, input word_t addr, input mem_op_t op,
                             input word_t wdata);
        t_inst[n_entries]   = inst;
        t_pc[n_entries]     = cur_pc;
        t_regwr[n_entries]  = regwr;
        t_rd[n_entries]     = rd;
        t_chkres[n_entries] = chkres;
        t_res[n_entries]    = res;
        t_redir[n_entries]  = redir;
        t_chktgt[n_entries] = chktgt;
        t_tgt[n_entries]    = tgt;
        t_memwr[n_entries]  = memwr;
        t_chkmem[n_entries] = chkmem;
        t_addr[n_entries]   = addr;
        t_op[n_entries]     = op;
        t_wdata[n_entries]  = wdata;
        n_entries++;
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic alu_entry(input inst_t inst, input reg_addr_t rd, input word_t res);
        add_entry(inst, 1'b1, rd, 1'b1, res, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic branch_entry(input inst_t inst, input logic taken, input word_t tgt);
        add_entry(inst, 1'b0, '0, 1'b0, '0, taken, 1'b1, tgt, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic jump_entry(input inst_t inst, input reg_addr_t rd, input word_t tgt);
        add_entry(inst, 1'b1, rd, 1'b1, cur_pc + 32'd4, 1'b1, 1'b1, tgt,
                  1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic mem_entry(input inst_t inst, input logic store, input reg_addr_t rd,
                             input word_t addr, input mem_op_t op, input word_t wdata);
        add_entry(inst, !store, rd, 1'b0, '0, 1'b0, 1'b0, '0, store, 1'b1, addr, op, wdata);
    endtask

    task automatic build_table();
        n_entries = 0;
        cur_pc    = 32'h0000_0100;
        // register-register ops
        alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 5'd10, 32'h0000_0008);
        alu_entry(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd11), 5'd11, 32'hFFFF_FFFE);
        alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd12), 5'd12, 32'h0000_0028);
        alu_entry(r_type(7'h00, 5'd2, 5'd4, 3'b101, 5'd13), 5'd13, 32'h1000_0000);
        alu_entry(r_type(7'h20, 5'd2, 5'd4, 3'b101, 5'd14), 5'd14, 32'hF000_0000);
        alu_entry(r_type(7'h00, 5'd1, 5'd3, 3'b010, 5'd15), 5'd15, 32'h0000_0001);
        alu_entry(r_type(7'h00, 5'd1, 5'd3, 3'b011, 5'd16), 5'd16, 32'h0000_0000);
        alu_entry(r_type(7'h00, 5'd6, 5'd7, 3'b100, 5'd17), 5'd17, 32'h70F0_F0F0);
        alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd18), 5'd18, 32'h0000_0007);
        alu_entry(r_type(7'h00, 5'd3, 5'd7, 3'b111, 5'd19), 5'd19, 32'h0F0F_0F00);
        alu_entry(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd29), 5'd29, 32'h0000_0005);
        // immediate forms
        alu_entry(i_type(12'hFFF, 5'd1, 3'b000, 5'd20, OPC_OP_IMM), 5'd20, 32'h0000_0004);
        alu_entry(i_type(12'hFF1, 5'd3, 3'b010, 5'd21, OPC_OP_IMM), 5'd21, 32'h0000_0001);
        alu_entry(i_type(12'hFFF, 5'd1, 3'b011, 5'd22, OPC_OP_IMM), 5'd22, 32'h0000_0001);
        alu_entry(i_type(12'h0F0, 5'd1, 3'b100, 5'd23, OPC_OP_IMM), 5'd23, 32'h0000_00F5);
        alu_entry(i_type(12'h100, 5'd2, 3'b110, 5'd24, OPC_OP_IMM), 5'd24, 32'h0000_0103);
        alu_entry(i_type(12'h0FF, 5'd7, 3'b111, 5'd25, OPC_OP_IMM), 5'd25, 32'h0000_000F);
        alu_entry(i_type(12'h004, 5'd1, 3'b001, 5'd26, OPC_OP_IMM), 5'd26, 32'h0000_0050);
        alu_entry(i_type(12'h004, 5'd4, 3'b101, 5'd27, OPC_OP_IMM), 5'd27, 32'h0800_0000);
        alu_entry(i_type(12'h404, 5'd4, 3'b101, 5'd28, OPC_OP_IMM), 5'd28, 32'hF800_0000);
        // upper immediates and jumps
        alu_entry({20'h12345, 5'd5, OPC_LUI}, 5'd5, 32'h1234_5000);
        alu_entry({20'h00001, 5'd6, OPC_AUIPC}, 5'd6, cur_pc + 32'h0000_1000);
        jump_entry(j_type(21'h000020, 5'd1), 5'd1, cur_pc + 32'h20);
        jump_entry(j_type(21'h1FFFF8, 5'd3), 5'd3, cur_pc - 32'h8);
        jump_entry(i_type(12'h007, 5'd5, 3'b000, 5'd2, OPC_JALR), 5'd2, 32'h0000_1006);
        // branches, x8 equals x1
        branch_entry(b_type(13'h0010, 5'd8, 5'd1, 3'b000), 1'b1, cur_pc + 32'h10);
        branch_entry(b_type(13'h0010, 5'd2, 5'd1, 3'b000), 1'b0, cur_pc + 32'h10);
        branch_entry(b_type(13'h0010, 5'd2, 5'd1, 3'b001), 1'b1, cur_pc + 32'h10);
        branch_entry(b_type(13'h0010, 5'd8, 5'd1, 3'b001), 1'b0, cur_pc + 32'h10);
        branch_entry(b_type(13'h1FF0, 5'd1, 5'd3, 3'b100), 1'b1, cur_pc - 32'h10);
        branch_entry(b_type(13'h0020, 5'd1, 5'd3, 3'b110), 1'b0, cur_pc + 32'h20);
        branch_entry(b_type(13'h0020, 5'd3, 5'd1, 3'b101), 1'b1, cur_pc + 32'h20);
        branch_entry(b_type(13'h0020, 5'd3, 5'd1, 3'b111), 1'b0, cur_pc + 32'h20);
        branch_entry(b_type(13'h0008, 5'd8, 5'd1, 3'b101), 1'b1, cur_pc + 32'h8);
        branch_entry(b_type(13'h0008, 5'd1, 5'd3, 3'b111), 1'b1, cur_pc + 32'h8);
        // loads and stores
        mem_entry(i_type(12'h008, 5'd5, 3'b010, 5'd9, OPC_LOAD), 1'b0, 5'd9,
                  32'h0000_1008, 3'b010, '0);
        mem_entry(i_type(12'hFFC, 5'd5, 3'b000, 5'd10, OPC_LOAD), 1'b0, 5'd10,
                  32'h0000_0FFC, 3'b000, '0);
        mem_entry(i_type(12'h002, 5'd3, 3'b101, 5'd11, OPC_LOAD), 1'b0, 5'd11,
                  32'hFFFF_FFF2, 3'b101, '0);
        mem_entry(s_type(12'h00C, 5'd7, 5'd5, 3'b010), 1'b1, '0,
                  32'h0000_100C, 3'b010, 32'h0F0F_0F0F);
        mem_entry(s_type(12'hFFF, 5'd6, 5'd1, 3'b000), 1'b1, '0,
                  32'h0000_0004, 3'b000, 32'h7FFF_FFFF);
        mem_entry(s_type(12'h010, 5'd2, 5'd4, 3'b001), 1'b1, '0,
                  32'h8000_0010, 3'b001, 32'h0000_0003);
        // unknown opcode is a no-op
        add_entry(32'hFFFF_FFFF, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    // watchdog sized by the table
    initial begin
        int limit;
        #1;
        limit = 4 + 15 + 4 + 20 * n_entries;
        repeat (limit) @(posedge clk);
        $display("run timed out before all instructions came out of the execute stage");
        $display("TESTS FAILED");
        $fatal(1);
    end

    // random back-pressure
    always @(posedge clk) begin
        logic [31:0] r;
        r = $urandom;
        if (i_arst_n) begin
            i_exu_ready <= r[0];
        end
    end

    // monitor, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        int k;
        if (!i_arst_n) begin
            check("o_exu_valid", o_exu_valid, 1'b0);
            check("o_inst_allow_in", o_inst_allow_in, 1'b1);
            was_stalled = 1'b0;
        end else begin
            check("o_inst_allow_in", o_inst_allow_in, !(o_exu_valid && !i_exu_ready));
            if (o_exu_valid && was_stalled) begin
                check("o_result", o_result, snap_result);
                check("o_redirect_pc", o_redirect_pc, snap_tgt);
                check("o_mem_addr", o_mem_addr, snap_addr);
            end
            was_stalled = o_exu_valid && !i_exu_ready;
            snap_result = o_result;
            snap_tgt    = o_redirect_pc;
            snap_addr   = o_mem_addr;
            if (o_exu_valid && i_exu_ready) begin
                if (issued_q.size() == 0) begin
                    $display("execute stage presented an instruction that was never issued");
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                k = issued_q.pop_front();
                check("o_reg_wr", o_reg_wr, t_regwr[k]);
                check("o_redirect", o_redirect, t_redir[k]);
                check("o_mem_wr", o_mem_wr, t_memwr[k]);
                if (t_regwr[k]) begin
                    check("o_rd", o_rd, t_rd[k]);
                end
                if (t_chkres[k]) begin
                    check("o_result", o_result, t_res[k]);
                end
                if (t_chktgt[k]) begin
                    check("o_redirect_pc", o_redirect_pc, t_tgt[k]);
                end
                if (t_chkmem[k]) begin
                    check("o_mem_addr", o_mem_addr, t_addr[k]);
                    check("o_mem_op", o_mem_op, t_op[k]);
                    if (t_memwr[k]) begin
                        check("o_mem_wdata", o_mem_wdata, t_wdata[k]);
                    end
                end
                pops++;
            end
        end
    end

    initial begin
        logic        acc;
        logic [31:0] gap;
        void'($urandom(32'h4af1f3a3));
        i_arst_n     = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_exu_ready  = 1'b0;
        i_wb_en      = 1'b0;
        i_wb_rd      = '0;
        i_wb_data    = '0;
        pops         = 0;
        was_stalled  = 1'b0;
        preload[1] = 32'h0000_0005;
        preload[2] = 32'h0000_0003;
        preload[3] = 32'hFFFF_FFF0;
        preload[4] = 32'h8000_0000;
        preload[5] = 32'h0000_1000;
        preload[6] = 32'h7FFF_FFFF;
        preload[7] = 32'h0F0F_0F0F;
        preload[8] = 32'h0000_0005;
        for (int i = 9; i <= 15; i++) begin
            preload[i] = 32'h0000_0100 * i;
        end
        build_table();

        repeat (4) @(posedge clk);
        i_arst_n <= 1'b1;

        // register preload over the write-back port
        for (int i = 1; i <= 15; i++) begin
            @(posedge clk);
            i_wb_en   <= 1'b1;
            i_wb_rd   <= reg_addr_t'(i);
            i_wb_data <= preload[i];
        end
        @(posedge clk);
        i_wb_en <= 1'b0;

        for (int e = 0; e < n_entries; e++) begin
            gap = $urandom % 3;
            if (gap != 0) begin
                i_inst_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            i_inst_valid <= 1'b1;
            i_inst       <= t_inst[e];
            i_pc         <= t_pc[e];
            do begin
                @(negedge clk);
                acc = o_inst_allow_in;
                @(posedge clk);
            end while (!acc);
            issued_q.push_back(e);
        end
        i_inst_valid <= 1'b0;

        wait (pops == n_entries);
        // the last instruction must have left the stage
        @(posedge clk);
        @(negedge clk);
        check("o_exu_valid", o_exu_valid, 1'b0);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* rv_core_ex.f */
rv_pkg.sv
rv_regfile.sv
rv_idu.sv
rv_id_exu_regs.sv
rv_exu.sv
rv_core_ex.sv
rv_core_ex_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core_ex testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core_ex.f --top-module rv_core_ex_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vrv_core_ex_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
